// File: include/mosaic_config.svh
// geometry sizes must be powers of two; pixel positions and raster addresses wrap by bit width
`ifndef MOSAIC_CONFIG_SVH
`define MOSAIC_CONFIG_SVH

// **************************************
// display and window geometry
// **************************************
`define DISP_H          16              // display pixels per line
`define DISP_V          8               // display lines per frame
`define MEM_H           (`DISP_H / 2)   // window pixels per line
`define MEM_V           (`DISP_V / 2)   // window lines per frame
`define NUM_SRC         4               // one source per quadrant

// **************************************
// bursts and buffering
// **************************************
`define WR_BURST_LEN    4               // pixels moved per write grant
`define RD_BURST_LEN    8               // reads issued per read burst

// write FIFO must hold at least one burst
`define SRC_FIFO_DEPTH  16
`define OUT_FIFO_DEPTH  32              // readback side

`endif

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator; passes only when the pass message shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f video_mosaic.f --top-module tb_video_mosaic -o sim_video_mosaic \
    && ./obj_dir/sim_video_mosaic | tee /dev/stderr \
        | grep -Fx "Test completed successfully" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: src/frame_memory.sv
// on-chip frame store; a read of the address being written returns the old pixel
`include "mosaic_config.svh"

module frame_memory import mosaic_pkg::*; (
    input logic        sys_clk,
    mem_port_if.memory mem
);

    localparam int WORDS = `DISP_H * `DISP_V;

    // ****************************************
    // storage, one pixel per raster position
    // ****************************************
    pixel_t ram [WORDS];

    // write port
    always_ff @(posedge sys_clk) begin
        if (mem.wr_en) begin
            ram[mem.wr_addr] <= mem.wr_data;
        end
    end

    // read port, one cycle latency
    always_ff @(posedge sys_clk) begin
        if (mem.rd_en) begin
            mem.rd_data <= ram[mem.rd_addr];    // held between reads
        end
    end

endmodule

// File: src/frame_reader.sv
// streams the raster into the readback FIFO after the first rd_restart; a restart mid-burst redirects the rest of it to address 0
`include "mosaic_config.svh"

module frame_reader import mosaic_pkg::*; (
    input  logic           sys_clk,
    input  logic           rst,
    input  logic           rd_restart,
    input  out_count_t     out_count,
    output logic           out_push,
    output readback_beat_t out_beat,
    mem_port_if.reader     mem
);

    localparam int BEAT_W = $clog2(`RD_BURST_LEN);
    localparam int FLY_W  = $clog2(`RD_BURST_LEN + 1);
    localparam logic [BEAT_W-1:0] BEAT_LAST = BEAT_W'(`RD_BURST_LEN - 1);
    localparam frame_addr_t LAST_ADDR = frame_addr_t'(`DISP_H * `DISP_V - 1);

    logic              running;                 // set by the first restart
    logic              bursting;
    logic [BEAT_W-1:0] beat;
    logic [FLY_W-1:0]  in_flight;               // reserved slots not yet counted by the FIFO
    logic              room_ok;
    logic              burst_start;
    logic              rd_valid;
    logic              ret_sol;
    frame_addr_t       rd_addr;
    frame_addr_t       ret_addr;                // address of the returning pixel

    // ****************************************
    // back-pressure
    // ****************************************
    assign room_ok     = int'(out_count) + int'(in_flight) + `RD_BURST_LEN <= `OUT_FIFO_DEPTH;
    assign burst_start = running && !bursting && room_ok;

    assign mem.rd_en   = bursting;
    assign mem.rd_addr = rd_addr;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            running   <= 1'b0;
            bursting  <= 1'b0;
            beat      <= '0;
            in_flight <= '0;
            rd_addr   <= '0;
            rd_valid  <= 1'b0;
        end else begin
            rd_valid  <= bursting;
            in_flight <= FLY_W'(int'(in_flight) + (burst_start ? `RD_BURST_LEN : 0)
                                - int'(out_push));
            if (burst_start) begin
                bursting <= 1'b1;
                beat     <= '0;
            end else if (bursting) begin
                beat <= beat + 1'b1;
                if (beat == BEAT_LAST) begin
                    bursting <= 1'b0;
                end
            end
            if (rd_restart) begin
                running <= 1'b1;
                rd_addr <= '0;
            end else if (bursting) begin
                rd_addr <= (rd_addr == LAST_ADDR) ? '0 : rd_addr + 1'b1;    // next frame
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (bursting) begin
            ret_addr <= rd_addr;                // lines up with rd_data
        end
    end

    // ****************************************
    // return path
    // ****************************************
    assign ret_sol  = (ret_addr % `DISP_H) == 0;
    assign out_push = rd_valid;
    assign out_beat = '{pixel: mem.rd_data, line_start: ret_sol};

    a_no_overflow : assert property (@(posedge sys_clk) disable iff (rst)
        out_push |-> (out_count < `OUT_FIFO_DEPTH))
        else $error("frame_reader push into full readback FIFO");

endmodule

// File: src/frame_writer.sv
// one write burst per grant; a source restart wins over its position step in the same cycle
`include "mosaic_config.svh"

module frame_writer import mosaic_pkg::*; (
    input  logic       sys_clk,
    input  logic       rst,
    input  src_count_t src_count [`NUM_SRC],
    input  pixel_t     src_head [`NUM_SRC],
    input  src_vec_t   frame_restart,
    input  src_vec_t   grant,
    output src_vec_t   src_pop,
    output src_vec_t   request,
    output logic       grant_take,
    mem_port_if.writer mem
);

    localparam int POS_W  = $clog2(`MEM_H * `MEM_V);
    localparam int ROW_W  = $clog2(`DISP_V);
    localparam int COL_W  = $clog2(`DISP_H);
    localparam int BEAT_W = $clog2(`WR_BURST_LEN);
    localparam logic [BEAT_W-1:0] BEAT_LAST = BEAT_W'(`WR_BURST_LEN - 1);

    logic [POS_W-1:0]  pos [`NUM_SRC];          // next pixel of each source frame
    logic [POS_W-1:0]  cur_pos;
    logic [ROW_W-1:0]  win_row;
    logic [COL_W-1:0]  win_col;
    logic [BEAT_W-1:0] beat;
    logic              busy;
    src_idx_t          sel;                     // source of the running burst
    src_idx_t          grant_idx;

    // ****************************************
    // request and grant
    // ****************************************
    always_comb begin
        for (int q = 0; q < `NUM_SRC; q++) begin
            request[q] = !busy && (src_count[q] >= `WR_BURST_LEN);
        end
    end

    always_comb begin
        grant_idx = '0;
        for (int q = 0; q < `NUM_SRC; q++) begin
            if (grant[q]) begin
                grant_idx = src_idx_t'(q);
            end
        end
    end

    assign grant_take = |grant;                 // request is already masked while busy

    // ****************************************
    // quadrant mapping
    // ****************************************
    assign cur_pos = pos[sel];
    assign win_row = ROW_W'(sel[1] * `MEM_V + cur_pos / `MEM_H);     // lower half for 2, 3
    assign win_col = COL_W'(sel[0] * `MEM_H + cur_pos % `MEM_H);     // right half for 1, 3

    assign mem.wr_en   = busy;
    assign mem.wr_addr = frame_addr_t'(win_row * `DISP_H + win_col);
    assign mem.wr_data = src_head[sel];
    assign src_pop     = busy ? (src_vec_t'(1) << sel) : '0;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            busy <= 1'b0;
            beat <= '0;
            sel  <= '0;
            for (int q = 0; q < `NUM_SRC; q++) begin
                pos[q] <= '0;
            end
        end else begin
            if (grant_take) begin
                busy <= 1'b1;
                beat <= '0;
                sel  <= grant_idx;
            end else if (busy) begin
                beat <= beat + 1'b1;
                if (beat == BEAT_LAST) begin
                    busy <= 1'b0;               // request reopens next cycle
                end
            end
            for (int q = 0; q < `NUM_SRC; q++) begin
                if (frame_restart[q]) begin
                    pos[q] <= '0;
                end else if (busy && sel == src_idx_t'(q)) begin
                    pos[q] <= pos[q] + 1'b1;    // wraps at window size
                end
            end
        end
    end

    a_take_idle : assert property (@(posedge sys_clk) disable iff (rst) grant_take |-> !busy)
        else $error("frame_writer took a grant during a burst");

endmodule

// File: src/mem_port_if.sv
// frame memory ports for one writer and one reader; read data is valid one cycle after rd_en
interface mem_port_if import mosaic_pkg::*; ();

    logic        wr_en;
    frame_addr_t wr_addr;
    pixel_t      wr_data;

    logic        rd_en;
    frame_addr_t rd_addr;
    pixel_t      rd_data;             // registered in the memory

    modport writer (
        output wr_en, wr_addr, wr_data
    );

    modport reader (
        output rd_en, rd_addr,
        input  rd_data
    );

    modport memory (
        input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
        output rd_data
    );

endinterface

// File: src/mosaic_pkg.sv
// mosaic types; all widths derive from mosaic_config.svh and assume exactly four sources
`include "mosaic_config.svh"

package mosaic_pkg;

    // 8 bits each of r, g, b
    typedef logic [23:0] pixel_t;

    // raster index over the whole display
    typedef logic [$clog2(`DISP_H * `DISP_V)-1:0] frame_addr_t;

    typedef logic [1:0] src_idx_t;                      // quadrant number
    typedef logic [`NUM_SRC-1:0] src_vec_t;             // one bit per source

    // fill levels, wide enough to hold a full FIFO
    typedef logic [$clog2(`SRC_FIFO_DEPTH + 1)-1:0] src_count_t;
    typedef logic [$clog2(`OUT_FIFO_DEPTH + 1)-1:0] out_count_t;

    // one readback word
    typedef struct packed {
        pixel_t pixel;
        logic   line_start;                             // first pixel of a display line
    } readback_beat_t;

endpackage

// File: src/sync_fifo.sv
// single-clock fall-through FIFO; DEPTH must be a power of two, push when full and pop when empty are ignored
module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic                       sys_clk,
    input  logic                       rst,
    input  logic                       push,
    input  payload_t                   push_data,
    input  logic                       pop,
    output payload_t                   head,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         store [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head  = store[rd_ptr];               // fall through, no read latency
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;        // wraps at DEPTH
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (do_push) begin
            store[wr_ptr] <= push_data;
        end
    end

    // producers and consumers must respect the flags
    a_no_push_full : assert property (@(posedge sys_clk) disable iff (rst) push |-> !full)
        else $error("sync_fifo push while full");
    a_no_pop_empty : assert property (@(posedge sys_clk) disable iff (rst) pop |-> !empty)
        else $error("sync_fifo pop while empty");

endmodule

// File: src/video_mosaic_top.sv
// four-window mosaic on one clock; pushes into a full source FIFO are lost, readback starts only after rd_rst
`include "mosaic_config.svh"

module video_mosaic_top import mosaic_pkg::*; (
    input  logic   sys_clk,
    input  logic   rst,
    input  logic   video0_wr_en,
    input  pixel_t video0_wr_data,
    input  logic   video0_wr_rst,
    input  logic   video1_wr_en,
    input  pixel_t video1_wr_data,
    input  logic   video1_wr_rst,
    input  logic   video2_wr_en,
    input  pixel_t video2_wr_data,
    input  logic   video2_wr_rst,
    input  logic   video3_wr_en,
    input  pixel_t video3_wr_data,
    input  logic   video3_wr_rst,
    input  logic   fifo_rd_en,
    output pixel_t fifo_rd_data,
    output logic   fifo_rd_sol,
    output logic   fifo_o_empty,
    input  logic   rd_rst,
    output logic   fifo_video0_full,
    output logic   fifo_video1_full,
    output logic   fifo_video2_full,
    output logic   fifo_video3_full,
    output logic   fifo_o_full
);

    // ****************************************
    // wires
    // ****************************************
    src_vec_t       src_push;
    src_vec_t       src_full;
    src_vec_t       src_pop;
    src_vec_t       frame_restart;
    src_vec_t       request;
    src_vec_t       grant;
    pixel_t         src_data [`NUM_SRC];
    pixel_t         src_head [`NUM_SRC];
    src_count_t     src_count [`NUM_SRC];
    logic           grant_take;
    logic           out_push;
    readback_beat_t out_beat;
    readback_beat_t out_head;
    out_count_t     out_count;

    mem_port_if mem ();

    assign src_push      = {video3_wr_en, video2_wr_en, video1_wr_en, video0_wr_en};
    assign src_data      = '{video0_wr_data, video1_wr_data, video2_wr_data, video3_wr_data};
    assign frame_restart = {video3_wr_rst, video2_wr_rst, video1_wr_rst, video0_wr_rst};
    assign {fifo_video3_full, fifo_video2_full, fifo_video1_full, fifo_video0_full} = src_full;
    assign fifo_rd_data  = out_head.pixel;
    assign fifo_rd_sol   = out_head.line_start;

    // ****************************************
    // instances
    // ****************************************
    for (genvar i = 0; i < `NUM_SRC; i++) begin : g_src_fifo
        sync_fifo #(
            .payload_t (pixel_t),
            .DEPTH     (`SRC_FIFO_DEPTH)
        ) u_src_fifo (
            .sys_clk   (sys_clk),
            .rst       (rst),
            .push      (src_push[i]),
            .push_data (src_data[i]),
            .pop       (src_pop[i]),
            .head      (src_head[i]),
            .empty     (),              // writer works from the count
            .full      (src_full[i]),
            .count     (src_count[i])
        );
    end

    write_arbiter u_write_arbiter (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .request    (request),
        .grant_take (grant_take),
        .grant      (grant)
    );

    frame_writer u_frame_writer (
        .sys_clk       (sys_clk),
        .rst           (rst),
        .src_count     (src_count),
        .src_head      (src_head),
        .frame_restart (frame_restart),
        .grant         (grant),
        .src_pop       (src_pop),
        .request       (request),
        .grant_take    (grant_take),
        .mem           (mem.writer)
    );

    frame_memory u_frame_memory (
        .sys_clk (sys_clk),
        .mem     (mem.memory)
    );

    frame_reader u_frame_reader (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .rd_restart (rd_rst),
        .out_count  (out_count),
        .out_push   (out_push),
        .out_beat   (out_beat),
        .mem        (mem.reader)
    );

    sync_fifo #(
        .payload_t (readback_beat_t),
        .DEPTH     (`OUT_FIFO_DEPTH)
    ) u_out_fifo (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .push      (out_push),
        .push_data (out_beat),
        .pop       (fifo_rd_en),
        .head      (out_head),
        .empty     (fifo_o_empty),
        .full      (fifo_o_full),
        .count     (out_count)          // back-pressure for the reader
    );

endmodule

// File: src/write_arbiter.sv
// round-robin grant over four sources; grant is combinational and held until grant_take
`include "mosaic_config.svh"

module write_arbiter import mosaic_pkg::*; (
    input  logic     sys_clk,
    input  logic     rst,
    input  src_vec_t request,
    input  logic     grant_take,
    output src_vec_t grant
);

    src_idx_t ptr;                              // highest priority source
    src_idx_t cand;
    src_idx_t grant_idx;
    logic     found;

    // first requester at or after the pointer
    always_comb begin
        grant     = '0;
        grant_idx = ptr;
        found     = 1'b0;
        cand      = ptr;
        for (int i = 0; i < `NUM_SRC; i++) begin
            cand = src_idx_t'(ptr + i);         // wraps over the sources
            if (!found && request[cand]) begin
                found     = 1'b1;
                grant_idx = cand;
            end
        end
        if (found) begin
            grant[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (grant_take) begin
            ptr <= grant_idx + 1'b1;            // winner goes to the back
        end
    end

    a_grant_onehot : assert property (@(posedge sys_clk) disable iff (rst) $onehot0(grant))
        else $error("arbiter grant not one-hot");
    a_grant_req : assert property (@(posedge sys_clk) disable iff (rst) (grant & ~request) == '0)
        else $error("arbiter granted a source without request");

endmodule

// File: verif/mosaic_patterns.txt
// one line per source row: lines 0-3 source 0, 4-7 source 1, 8-11 source 2, 12-15 source 3
// each line holds MEM_H pixels of that row, left to right, digits are source, row, column, A5, column
000A50 001A51 002A52 003A53 004A54 005A55 006A56 007A57
010A50 011A51 012A52 013A53 014A54 015A55 016A56 017A57
020A50 021A51 022A52 023A53 024A54 025A55 026A56 027A57
030A50 031A51 032A52 033A53 034A54 035A55 036A56 037A57
100A50 101A51 102A52 103A53 104A54 105A55 106A56 107A57
110A50 111A51 112A52 113A53 114A54 115A55 116A56 117A57
120A50 121A51 122A52 123A53 124A54 125A55 126A56 127A57
130A50 131A51 132A52 133A53 134A54 135A55 136A56 137A57
200A50 201A51 202A52 203A53 204A54 205A55 206A56 207A57
210A50 211A51 212A52 213A53 214A54 215A55 216A56 217A57
220A50 221A51 222A52 223A53 224A54 225A55 226A56 227A57
230A50 231A51 232A52 233A53 234A54 235A55 236A56 237A57
300A50 301A51 302A52 303A53 304A54 305A55 306A56 307A57
310A50 311A51 312A52 313A53 314A54 315A55 316A56 317A57
320A50 321A51 322A52 323A53 324A54 325A55 326A56 327A57
330A50 331A51 332A52 333A53 334A54 335A55 336A56 337A57

// File: verif/tb_video_mosaic.sv
// run from the project root so that verif/mosaic_patterns.txt is found
`include "mosaic_config.svh"

module tb_video_mosaic import mosaic_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WIN_PIX   = `MEM_H * `MEM_V;
    localparam int FRAME_PIX = `DISP_H * `DISP_V;
    localparam int WAIT_MAX  = 500;             // cycles per wait loop
    localparam int SETTLE    = 200;             // write path drains well within this

    logic     sys_clk;
    logic     rst;
    logic     fifo_rd_en;
    logic     rd_rst;
    src_vec_t wr_en;
    src_vec_t wr_rst;
    pixel_t   wr_data [`NUM_SRC];
    pixel_t   fifo_rd_data;
    logic     fifo_rd_sol;
    logic     fifo_o_empty;
    logic     fifo_o_full;
    src_vec_t src_full;

    pixel_t   patterns [`NUM_SRC * WIN_PIX];    // source major, then row, then column
    int       check_errors;
    int       timeout_errors;

    video_mosaic_top dut (
        .sys_clk          (sys_clk),
        .rst              (rst),
        .video0_wr_en     (wr_en[0]),
        .video0_wr_data   (wr_data[0]),
        .video0_wr_rst    (wr_rst[0]),
        .video1_wr_en     (wr_en[1]),
        .video1_wr_data   (wr_data[1]),
        .video1_wr_rst    (wr_rst[1]),
        .video2_wr_en     (wr_en[2]),
        .video2_wr_data   (wr_data[2]),
        .video2_wr_rst    (wr_rst[2]),
        .video3_wr_en     (wr_en[3]),
        .video3_wr_data   (wr_data[3]),
        .video3_wr_rst    (wr_rst[3]),
        .fifo_rd_en       (fifo_rd_en),
        .fifo_rd_data     (fifo_rd_data),
        .fifo_rd_sol      (fifo_rd_sol),
        .fifo_o_empty     (fifo_o_empty),
        .rd_rst           (rd_rst),
        .fifo_video0_full (src_full[0]),
        .fifo_video1_full (src_full[1]),
        .fifo_video2_full (src_full[2]),
        .fifo_video3_full (src_full[3]),
        .fifo_o_full      (fifo_o_full)
    );

    initial begin
        sys_clk = 1'b0;
        forever begin
            #20 sys_clk = ~sys_clk;             // 40 ns period
        end
    end

    // ****************************************
    // helpers
    // ****************************************
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            check_errors++;
        end
    endtask

    // display raster index back to source window and pixel position
    function automatic pixel_t expected_pixel(input int raster);
        int row;
        int col;
        int q;
        int k;
        row = raster / `DISP_H;
        col = raster % `DISP_H;
        q   = (row / `MEM_V) * 2 + col / `MEM_H;
        k   = (row % `MEM_V) * `MEM_H + col % `MEM_H;
        return patterns[q * WIN_PIX + k];
    endfunction

    task automatic push_step(input src_vec_t mask, input int k, input logic invert);
        int waited;
        waited = 0;
        @(negedge sys_clk);
        while ((src_full & mask) != '0 && waited < WAIT_MAX) begin
            @(negedge sys_clk);
            waited++;
        end
        if ((src_full & mask) != '0) begin
            $display("timeout at %0d ns: source FIFO stayed full at pixel %0d", $time, k);
            timeout_errors++;
        end
        @(posedge sys_clk);
        for (int q = 0; q < `NUM_SRC; q++) begin
            wr_data[q] <= invert ? ~patterns[q * WIN_PIX + k] : patterns[q * WIN_PIX + k];
        end
        wr_en <= mask;
        @(posedge sys_clk);
        wr_en <= '0;                            // push taken on this edge
    endtask

    task automatic pop_and_check(input int raster);
        int waited;
        waited = 0;
        @(negedge sys_clk);
        while (fifo_o_empty && waited < WAIT_MAX) begin
            @(negedge sys_clk);
            waited++;
        end
        if (fifo_o_empty) begin
            $display("timeout at %0d ns: no readback pixel arrived for index %0d", $time, raster);
            timeout_errors++;
        end else begin
            check_value(fifo_rd_data, expected_pixel(raster % FRAME_PIX),
                        $sformatf("readback pixel %0d", raster));
            check_value(fifo_rd_sol, (raster % `DISP_H) == 0,
                        $sformatf("line start of pixel %0d", raster));
            @(posedge sys_clk);
            fifo_rd_en <= 1'b1;
            @(posedge sys_clk);
            fifo_rd_en <= 1'b0;
        end
    endtask

    // ****************************************
    // sequence
    // ****************************************
    initial begin
        void'($urandom(32'h9411d075));
        check_errors   = 0;
        timeout_errors = 0;
        $readmemh("verif/mosaic_patterns.txt", patterns);
        rst        <= 1'b1;
        fifo_rd_en <= 1'b0;
        rd_rst     <= 1'b0;
        wr_en      <= '0;
        wr_rst     <= '0;
        for (int q = 0; q < `NUM_SRC; q++) begin
            wr_data[q] <= '0;
        end
        repeat (10) @(posedge sys_clk);
        rst <= 1'b0;

        @(negedge sys_clk);
        check_value(fifo_o_empty, 1'b1, "readback FIFO empty after reset");
        check_value(src_full, '0, "source FIFOs not full after reset");
        check_value(fifo_o_full, 1'b0, "readback FIFO not full after reset");

        // stale half frame on source 1 that the restart discards
        for (int k = 0; k < WIN_PIX / 2; k++) begin
            push_step(4'b0010, k, 1'b1);
            repeat ($urandom % 3) @(posedge sys_clk);
        end
        repeat (SETTLE) @(posedge sys_clk);
        wr_rst <= 4'b0010;
        @(posedge sys_clk);
        wr_rst <= '0;

        // all four sources on the same cycles with random gaps
        for (int k = 0; k < WIN_PIX; k++) begin
            push_step(4'b1111, k, 1'b0);
            repeat ($urandom % 3) @(posedge sys_clk);
        end
        repeat (SETTLE) @(posedge sys_clk);
        @(negedge sys_clk);
        check_value(fifo_o_empty, 1'b1, "no readback before rd_rst");

        @(posedge sys_clk);
        rd_rst <= 1'b1;
        @(posedge sys_clk);
        rd_rst <= 1'b0;

        // two frames with the second one after the wrap
        for (int i = 0; i < 2 * FRAME_PIX; i++) begin
            if (i == FRAME_PIX / 2) begin
                repeat (200) @(posedge sys_clk);    // consumer stalls mid-frame
                @(negedge sys_clk);
                check_value(fifo_o_full, 1'b1, "readback FIFO filled during stall");
            end
            pop_and_check(i);
        end

        $display("closing report: %0d check errors, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: video_mosaic.f
+incdir+include
src/mosaic_pkg.sv
src/mem_port_if.sv
src/sync_fifo.sv
src/write_arbiter.sv
src/frame_writer.sv
src/frame_memory.sv
src/frame_reader.sv
src/video_mosaic_top.sv
verif/tb_video_mosaic.sv
